// File: verilog/conv_pkg.sv
package conv_pkg;

    // Image geometry
    localparam int IMG_WIDTH  = 8;
    localparam int IMG_HEIGHT = 6;

    // Square kernel side
    localparam int KERNEL = 3;

    // One channel unit per input channel
    localparam int IN_CHANNELS = 2;

    // Signed Q7.8 fixed point
    localparam int PIXEL_BITS = 16;
    localparam int FRAC_BITS  = 8;

    // Valid convolution output size at stride 1
    localparam int OUT_WIDTH  = IMG_WIDTH - KERNEL + 1;
    localparam int OUT_HEIGHT = IMG_HEIGHT - KERNEL + 1;

    // Counters must be able to reach the image size
    localparam int COL_BITS = $clog2(IMG_WIDTH + 1);
    localparam int ROW_BITS = $clog2(IMG_HEIGHT + 1);

    // Clamp negative results to zero
    localparam bit RELU_EN = 1'b1;

    typedef logic signed [PIXEL_BITS-1:0] pixel_t;

    // One stream beat carries every input channel
    typedef pixel_t [IN_CHANNELS-1:0] pixel_vec_t;

    // Indexed [row][col], row 0 oldest and col 0 leftmost
    typedef pixel_t [KERNEL-1:0][KERNEL-1:0] window_t;

    typedef window_t [IN_CHANNELS-1:0] window_vec_t;
    typedef window_t [IN_CHANNELS-1:0] kernel_vec_t;
    typedef pixel_t  [IN_CHANNELS-1:0] psum_vec_t;

endpackage

// File: verilog/window_feed.sv
`timescale 1ns/1ps

module window_feed (
    input  logic                  clk,
    input  logic                  reset,
    input  conv_pkg::pixel_vec_t  i_pixels,
    input  logic                  i_valid,
    input  logic                  i_last,
    input  logic                  i_adv,
    output conv_pkg::window_vec_t o_win,
    output logic                  o_win_valid,
    output logic                  o_win_last
);

    // Line memories, entry 0 holds the oldest buffered row
    conv_pkg::pixel_vec_t line_mem [conv_pkg::KERNEL-1][conv_pkg::IMG_WIDTH];

    // Window registers for all channels
    conv_pkg::window_vec_t win_q;

    // Position of the next incoming pixel
    logic [conv_pkg::COL_BITS-1:0] col_q;
    logic [conv_pkg::ROW_BITS-1:0] row_q;

    // Line memory address taken from the column counter
    logic [$clog2(conv_pkg::IMG_WIDTH)-1:0] col_addr;

    logic accept;
    logic win_done;
    logic win_valid_q;
    logic win_last_q;

    // Beat transfers only when the whole pipeline moves
    assign accept = i_valid && i_adv;

    assign col_addr = col_q[$clog2(conv_pkg::IMG_WIDTH)-1:0];

    // New pixel lands at the bottom-right corner of a full window
    assign win_done = (row_q >= conv_pkg::ROW_BITS'(conv_pkg::KERNEL - 1)) &&
                      (col_q >= conv_pkg::COL_BITS'(conv_pkg::KERNEL - 1));

    // Shift-through line memories
    // Each row moves one memory older, the newest row takes the pixel
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int r = 0; r < conv_pkg::KERNEL - 2; r++) begin
                line_mem[r][col_addr] <= line_mem[r+1][col_addr];
            end
            line_mem[conv_pkg::KERNEL-2][col_addr] <= i_pixels;
        end
    end

    // Window shift per channel
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int ch = 0; ch < conv_pkg::IN_CHANNELS; ch++) begin
                // Every row moves one column left
                for (int r = 0; r < conv_pkg::KERNEL; r++) begin
                    for (int c = 0; c < conv_pkg::KERNEL - 1; c++) begin
                        win_q[ch][r][c] <= win_q[ch][r][c+1];
                    end
                end
                // Right column from the older rows at this column
                for (int r = 0; r < conv_pkg::KERNEL - 1; r++) begin
                    win_q[ch][r][conv_pkg::KERNEL-1] <= line_mem[r][col_addr][ch];
                end
                // Bottom-right is the pixel arriving now
                win_q[ch][conv_pkg::KERNEL-1][conv_pkg::KERNEL-1] <= i_pixels[ch];
            end
        end
    end

    // Position counters and window flags
    always_ff @(posedge clk) begin
        if (reset) begin
            col_q       <= '0;
            row_q       <= '0;
            win_valid_q <= 1'b0;
            win_last_q  <= 1'b0;
        end else begin
            // Flags move with every advance so bubbles travel too
            if (i_adv) begin
                win_valid_q <= accept && win_done;
                win_last_q  <= accept && win_done && i_last;
            end
            if (accept) begin
                if (i_last) begin
                    // Next image starts at the top-left
                    col_q <= '0;
                    row_q <= '0;
                end else if (col_q == conv_pkg::COL_BITS'(conv_pkg::IMG_WIDTH - 1)) begin
                    col_q <= '0;
                    row_q <= row_q + 1'b1;
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end
        end
    end

    assign o_win       = win_q;
    assign o_win_valid = win_valid_q;
    assign o_win_last  = win_last_q;

    // No beat beyond the last row of an image
    a_row_in_range: assert property (
        @(posedge clk) disable iff (reset)
        accept |-> (row_q != conv_pkg::ROW_BITS'(conv_pkg::IMG_HEIGHT))
    );

    // Image end marker only on the final pixel of the frame
    a_last_position: assert property (
        @(posedge clk) disable iff (reset)
        (accept && i_last) |->
            (row_q == conv_pkg::ROW_BITS'(conv_pkg::IMG_HEIGHT - 1)) &&
            (col_q == conv_pkg::COL_BITS'(conv_pkg::IMG_WIDTH - 1))
    );

endmodule

// File: verilog/channel_mac.sv
`timescale 1ns/1ps

module channel_mac (
    input  logic              clk,
    input  logic              reset,
    input  logic              i_adv,
    input  conv_pkg::window_t i_win,
    input  logic              i_win_valid,
    input  logic              i_win_last,
    input  conv_pkg::window_t i_weights,
    output conv_pkg::pixel_t  o_psum,
    output logic              o_valid,
    output logic              o_last
);

    // Full-width products, one per kernel tap
    logic signed [2*conv_pkg::PIXEL_BITS-1:0] prod_q [conv_pkg::KERNEL*conv_pkg::KERNEL];
    logic prod_valid_q;
    logic prod_last_q;

    conv_pkg::pixel_t next_sum;
    conv_pkg::pixel_t sum_q;
    logic sum_valid_q;
    logic sum_last_q;

    // Stage one multiplies every pixel by its weight
    always_ff @(posedge clk) begin
        if (i_adv) begin
            for (int r = 0; r < conv_pkg::KERNEL; r++) begin
                for (int c = 0; c < conv_pkg::KERNEL; c++) begin
                    prod_q[r*conv_pkg::KERNEL + c] <= $signed(i_win[r][c]) *
                                                      $signed(i_weights[r][c]);
                end
            end
        end
    end

    // Drop the fraction bits and wrap to the pixel width
    // Slicing above the fraction equals the arithmetic shift then truncation
    always_comb begin
        next_sum = '0;
        for (int i = 0; i < conv_pkg::KERNEL * conv_pkg::KERNEL; i++) begin
            next_sum = next_sum + prod_q[i][conv_pkg::FRAC_BITS +: conv_pkg::PIXEL_BITS];
        end
    end

    // Stage two holds the partial sum
    always_ff @(posedge clk) begin
        if (i_adv) begin
            sum_q <= next_sum;
        end
    end

    // Valid and last follow the data through both stages
    always_ff @(posedge clk) begin
        if (reset) begin
            prod_valid_q <= 1'b0;
            prod_last_q  <= 1'b0;
            sum_valid_q  <= 1'b0;
            sum_last_q   <= 1'b0;
        end else if (i_adv) begin
            prod_valid_q <= i_win_valid;
            prod_last_q  <= i_win_last;
            sum_valid_q  <= prod_valid_q;
            sum_last_q   <= prod_last_q;
        end
    end

    assign o_psum  = sum_q;
    assign o_valid = sum_valid_q;
    assign o_last  = sum_last_q;

endmodule

// File: verilog/channel_sum.sv
`timescale 1ns/1ps

module channel_sum (
    input  logic                             clk,
    input  logic                             reset,
    input  conv_pkg::psum_vec_t              i_psums,
    input  logic [conv_pkg::IN_CHANNELS-1:0] i_valids,
    input  logic [conv_pkg::IN_CHANNELS-1:0] i_lasts,
    input  conv_pkg::pixel_t                 i_bias,
    input  logic                             i_ready,
    output logic                             o_adv,
    output conv_pkg::pixel_t                 o_data,
    output logic                             o_valid,
    output logic                             o_last
);

    conv_pkg::pixel_t total;
    conv_pkg::pixel_t activated;
    conv_pkg::pixel_t data_q;
    logic valid_q;
    logic last_q;

    // Pipeline moves when the output register is free or being drained
    assign o_adv = !valid_q || i_ready;

    // Bias plus every channel, wrapping at the pixel width
    always_comb begin
        total = i_bias;
        for (int ch = 0; ch < conv_pkg::IN_CHANNELS; ch++) begin
            total = total + i_psums[ch];
        end
    end

    // ReLU on the sign bit
    assign activated = (conv_pkg::RELU_EN && total[conv_pkg::PIXEL_BITS-1]) ? '0 : total;

    // Output data register
    always_ff @(posedge clk) begin
        if (o_adv) begin
            data_q <= activated;
        end
    end

    // All channels run in lockstep so channel 0 speaks for the rest
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else if (o_adv) begin
            valid_q <= i_valids[0];
            last_q  <= i_lasts[0];
        end
    end

    assign o_data  = data_q;
    assign o_valid = valid_q;
    assign o_last  = last_q;

    // Channel units share one advance and must never drift apart
    a_channels_aligned: assert property (
        @(posedge clk) disable iff (reset)
        (i_valids == {conv_pkg::IN_CHANNELS{i_valids[0]}}) &&
        (i_lasts == {conv_pkg::IN_CHANNELS{i_lasts[0]}})
    );

endmodule

// File: verilog/conv_top.sv
`timescale 1ns/1ps

module conv_top (
    input  logic                  clk,
    input  logic                  reset,
    input  conv_pkg::pixel_vec_t  i_pixels,
    input  logic                  i_valid,
    input  logic                  i_last,
    input  logic                  o_ready,
    input  conv_pkg::kernel_vec_t i_weights,
    input  conv_pkg::pixel_t      i_bias,
    output logic                  i_ready,
    output conv_pkg::pixel_t      o_data,
    output logic                  o_valid,
    output logic                  o_last
);

    // Shared advance strobe from the drain stage
    logic adv;

    // Window feeder outputs
    conv_pkg::window_vec_t win;
    logic win_valid;
    logic win_last;

    // Per-channel partial sums and flags
    conv_pkg::psum_vec_t psums;
    logic [conv_pkg::IN_CHANNELS-1:0] valids;
    logic [conv_pkg::IN_CHANNELS-1:0] lasts;

    // Source sees ready exactly when the pipeline advances
    assign i_ready = adv;

    window_feed window_feed_inst (
        .clk         (clk),
        .reset       (reset),
        .i_pixels    (i_pixels),
        .i_valid     (i_valid),
        .i_last      (i_last),
        .i_adv       (adv),
        .o_win       (win),
        .o_win_valid (win_valid),
        .o_win_last  (win_last)
    );

    // One multiply-accumulate unit per input channel
    for (genvar k = 0; k < conv_pkg::IN_CHANNELS; k++) begin : g_channel
        channel_mac channel_mac_inst (
            .clk         (clk),
            .reset       (reset),
            .i_adv       (adv),
            .i_win       (win[k]),
            .i_win_valid (win_valid),
            .i_win_last  (win_last),
            .i_weights   (i_weights[k]),
            .o_psum      (psums[k]),
            .o_valid     (valids[k]),
            .o_last      (lasts[k])
        );
    end

    channel_sum channel_sum_inst (
        .clk      (clk),
        .reset    (reset),
        .i_psums  (psums),
        .i_valids (valids),
        .i_lasts  (lasts),
        .i_bias   (i_bias),
        .i_ready  (o_ready),
        .o_adv    (adv),
        .o_data   (o_data),
        .o_valid  (o_valid),
        .o_last   (o_last)
    );

endmodule

// File: include/conv_ref_model.svh
`ifndef CONV_REF_MODEL_SVH
`define CONV_REF_MODEL_SVH

// Expected output for the window with its top-left pixel at out_row, out_col
// Exact integer products, each scaled down by the fraction, wrapped to the pixel width
function automatic conv_pkg::pixel_t conv_ref_window(
    input conv_pkg::pixel_vec_t  img [conv_pkg::IMG_HEIGHT][conv_pkg::IMG_WIDTH],
    input conv_pkg::kernel_vec_t weights,
    input conv_pkg::pixel_t      bias,
    input int                    out_row,
    input int                    out_col
);
    longint prod;
    longint psum;
    longint total;
    conv_pkg::pixel_t result;

    total = longint'(bias);
    for (int ch = 0; ch < conv_pkg::IN_CHANNELS; ch++) begin
        psum = 0;
        for (int r = 0; r < conv_pkg::KERNEL; r++) begin
            for (int c = 0; c < conv_pkg::KERNEL; c++) begin
                prod = longint'(img[out_row + r][out_col + c][ch]) *
                       longint'(weights[ch][r][c]);
                // Arithmetic shift rounds toward minus infinity
                psum = psum + (prod >>> conv_pkg::FRAC_BITS);
            end
        end
        // Channel sum wraps at the pixel width
        psum  = longint'(conv_pkg::pixel_t'(psum));
        total = total + psum;
    end
    result = conv_pkg::pixel_t'(total);

    // Negative results clamp to zero
    if (conv_pkg::RELU_EN && result < 0) begin
        result = '0;
    end
    return result;
endfunction

// Appends every expected output of one image in row-major order
function automatic void conv_ref_image(
    input conv_pkg::pixel_vec_t  img [conv_pkg::IMG_HEIGHT][conv_pkg::IMG_WIDTH],
    input conv_pkg::kernel_vec_t weights,
    input conv_pkg::pixel_t      bias,
    ref   conv_pkg::pixel_t      exp_q [$]
);
    for (int orow = 0; orow < conv_pkg::OUT_HEIGHT; orow++) begin
        for (int ocol = 0; ocol < conv_pkg::OUT_WIDTH; ocol++) begin
            exp_q.push_back(conv_ref_window(img, weights, bias, orow, ocol));
        end
    end
endfunction

`endif

// File: tb/tb_conv_top.sv
`timescale 1ns/1ps

module tb_conv_top;

    localparam int SEED         = 59155;
    localparam int NUM_IMAGES   = 3;
    localparam int STALL_LIMIT  = 200;
    localparam int DRAIN_CYCLES = 8;
    localparam int OUT_PER_IMG  = conv_pkg::OUT_WIDTH * conv_pkg::OUT_HEIGHT;

    logic                  clk;
    logic                  reset;
    conv_pkg::pixel_vec_t  i_pixels;
    logic                  i_valid;
    logic                  i_last;
    logic                  o_ready;
    conv_pkg::kernel_vec_t i_weights;
    conv_pkg::pixel_t      i_bias;
    logic                  i_ready;
    conv_pkg::pixel_t      o_data;
    logic                  o_valid;
    logic                  o_last;

    // Input beats and expected results for the images of one test
    conv_pkg::pixel_vec_t beat_q [$];
    bit                   beat_last_q [$];
    conv_pkg::pixel_t     exp_data_q [$];
    bit                   exp_last_q [$];

    int total_checks;
    int total_errors;
    int zero_outputs;
    bit timed_out;

    `include "conv_ref_model.svh"

    conv_top conv_top_inst (
        .clk       (clk),
        .reset     (reset),
        .i_pixels  (i_pixels),
        .i_valid   (i_valid),
        .i_last    (i_last),
        .o_ready   (o_ready),
        .i_weights (i_weights),
        .i_bias    (i_bias),
        .i_ready   (i_ready),
        .o_data    (o_data),
        .o_valid   (o_valid),
        .o_last    (o_last)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Zero limit means any 16-bit value
    function automatic conv_pkg::pixel_t rand_pixel(input int limit);
        int v;
        if (limit == 0) begin
            v = int'($urandom);
        end else begin
            v = int'($urandom_range(2 * limit)) - limit;
        end
        return conv_pkg::pixel_t'(v);
    endfunction

    // Random images, their beats and the expected outputs per window
    task automatic build_stream(input conv_pkg::kernel_vec_t weights,
                                input conv_pkg::pixel_t bias, input int pix_limit);
        conv_pkg::pixel_vec_t img [conv_pkg::IMG_HEIGHT][conv_pkg::IMG_WIDTH];
        for (int n = 0; n < NUM_IMAGES; n++) begin
            for (int r = 0; r < conv_pkg::IMG_HEIGHT; r++) begin
                for (int c = 0; c < conv_pkg::IMG_WIDTH; c++) begin
                    for (int ch = 0; ch < conv_pkg::IN_CHANNELS; ch++) begin
                        img[r][c][ch] = rand_pixel(pix_limit);
                    end
                    beat_q.push_back(img[r][c]);
                    // Last flag on the bottom-right pixel only
                    beat_last_q.push_back(r == conv_pkg::IMG_HEIGHT - 1 &&
                                          c == conv_pkg::IMG_WIDTH - 1);
                end
            end
            conv_ref_image(img, weights, bias, exp_data_q);
            for (int k = 0; k < OUT_PER_IMG; k++) begin
                exp_last_q.push_back(k == OUT_PER_IMG - 1);
            end
        end
    endtask

    // Compare one transfer against the head of the expected queues
    task automatic check_output();
        conv_pkg::pixel_t exp_data;
        bit exp_last;
        exp_data = exp_data_q.pop_front();
        exp_last = exp_last_q.pop_front();
        total_checks++;
        if (exp_data == '0) zero_outputs++;
        assert (o_data === exp_data) else begin
            $display("Error: o_data 0x%h, expected 0x%h", o_data, exp_data);
            total_errors++;
        end
        assert (o_last === exp_last) else begin
            $display("Error: o_last 0x%h, expected 0x%h", o_last, exp_last);
            total_errors++;
        end
    endtask

    // Source keeps a refused beat, otherwise presents the next one or a gap
    task automatic drive_source(input int beat_idx, input bit hold);
        if (!hold) begin
            if (beat_idx < beat_q.size() && $urandom_range(3) != 0) begin
                i_pixels = beat_q[beat_idx];
                i_last   = beat_last_q[beat_idx];
                i_valid  = 1'b1;
            end else begin
                i_valid = 1'b0;
                i_last  = 1'b0;
            end
        end
        // Sink stalls about three cycles in ten
        o_ready = ($urandom_range(9) >= 3);
    endtask

    // Runs until every expected result arrived or the stream stops moving
    task automatic run_stream(output int received, output int consumed);
        int idle;
        bit in_xfer;
        bit out_xfer;
        idle     = 0;
        received = 0;
        consumed = 0;
        drive_source(consumed, 1'b0);
        while (exp_data_q.size() > 0 && !timed_out) begin
            // Handshakes sampled mid-cycle, transfer on the next edge
            @(negedge clk);
            in_xfer  = i_valid && i_ready;
            out_xfer = o_valid && o_ready;
            if (out_xfer) begin
                check_output();
                received++;
            end
            if (in_xfer || out_xfer) idle = 0;
            else idle++;
            if (idle >= STALL_LIMIT) begin
                timed_out = 1'b1;
                $display("Timeout: no beat or result moved for %0d cycles", STALL_LIMIT);
            end
            @(posedge clk);
            #1;
            if (in_xfer) consumed++;
            drive_source(consumed, i_valid && !in_xfer);
        end
        i_valid = 1'b0;
        i_last  = 1'b0;
        o_ready = 1'b1;
    endtask

    task automatic run_test(input string name, input int pix_limit, input int wt_limit,
                            input int bias_lo, input int bias_hi);
        conv_pkg::kernel_vec_t weights;
        conv_pkg::pixel_t bias;
        int errors_before;
        int received;
        int consumed;
        if (timed_out) return;
        errors_before = total_errors;
        zero_outputs  = 0;
        for (int ch = 0; ch < conv_pkg::IN_CHANNELS; ch++) begin
            for (int r = 0; r < conv_pkg::KERNEL; r++) begin
                for (int c = 0; c < conv_pkg::KERNEL; c++) begin
                    weights[ch][r][c] = rand_pixel(wt_limit);
                end
            end
        end
        bias = conv_pkg::pixel_t'(int'($urandom_range(bias_hi - bias_lo)) + bias_lo);
        // Configuration changes only while the pipeline is empty
        i_weights = weights;
        i_bias    = bias;
        beat_q.delete();
        beat_last_q.delete();
        exp_data_q.delete();
        exp_last_q.delete();
        build_stream(weights, bias, pix_limit);
        run_stream(received, consumed);
        if (!timed_out) begin
            assert (consumed == beat_q.size()) else begin
                $display("Only %0d of %0d input beats were accepted", consumed, beat_q.size());
                total_errors++;
            end
            // Nothing may follow the final result
            repeat (DRAIN_CYCLES) begin
                @(negedge clk);
                assert (!o_valid) else begin
                    $display("An extra output appeared after the last expected result");
                    total_errors++;
                end
            end
            @(posedge clk);
            #1;
        end
        $display("%s: %0d outputs over %0d images, %0d zero, %0d errors", name, received,
                 NUM_IMAGES, zero_outputs, total_errors - errors_before);
    endtask

    initial begin
        void'($urandom(SEED));
        reset        = 1'b1;
        i_pixels     = '0;
        i_valid      = 1'b0;
        i_last       = 1'b0;
        o_ready      = 1'b1;
        i_weights    = '0;
        i_bias       = '0;
        total_checks = 0;
        total_errors = 0;
        zero_outputs = 0;
        timed_out    = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        // Idle state before the first beat
        @(negedge clk);
        total_checks++;
        assert (!o_valid && i_ready) else begin
            $display("Error: o_valid 0x%h i_ready 0x%h after reset, expected 0x0 and 0x1",
                     o_valid, i_ready);
            total_errors++;
        end
        $display("Reset state: o_valid %0b, i_ready %0b", o_valid, i_ready);
        @(posedge clk);
        #1;

        run_test("Small values, zero bias", 512, 128, 0, 0);
        run_test("Full-range values with wrap", 0, 0, -32768, 32767);
        run_test("Negative bias with ReLU", 512, 128, -4096, -1024);

        $display("Checks: %0d, errors: %0d", total_checks, total_errors);
        if (timed_out || total_errors != 0) begin
            $display("test failed");
        end else begin
            $display("test passed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+include
verilog/conv_pkg.sv
verilog/window_feed.sv
verilog/channel_mac.sv
verilog/channel_sum.sv
verilog/conv_top.sv
tb/tb_conv_top.sv

// File: Makefile
# Verilator simulation of the convolution engine

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_conv_top
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
